/* all.f */
+incdir+design
design/coco_cfg_pkg.sv
design/coco_audio_pkg.sv
design/coco_cfg_if.sv
design/coco_ctl_regs.sv
design/cas_level_detect.sv
design/machine_reset_seq.sv
design/cas_audio_mix.sv
design/coco_glue_top.sv
verification/tb_coco_glue.sv

/* design/cas_audio_mix.sv */
// cassette source select and audio sample assembly.
// the core gets the adc bit or the tape player bit; the sample stacks the
// 1-bit sound on top of the 6-bit dac level, with the monitored cassette
// mixed in at a low weight. both outputs are registered once.

module cas_audio_mix
(
	input  logic                          clk_sys,
	input  logic                          i_rst_n,
	coco_cfg_if.mix                       cfg,
	input  logic                          i_adc_cas_bit,
	input  logic                          i_tape_bit,
	input  logic                          i_snd_bit,
	input  coco_audio_pkg::snd_level_t    i_snd_level,
	output logic                          o_cas_to_core,
	output coco_audio_pkg::audio_sample_t o_audio_sample
);
	import coco_audio_pkg::*;

	logic          cas_src;
	logic          mon_bit;
	audio_sample_t sample_nxt;

	assign cas_src = cfg.tape_src_adc ? i_adc_cas_bit : i_tape_bit;
	assign mon_bit = cfg.monitor_tape & cas_src;

	// sound bit loudest, then level, cassette toggles level bit 5
	assign sample_nxt = {i_snd_bit, i_snd_level[11:6], i_snd_level[5] ^ mon_bit,
		i_snd_level[4:0], 3'b000};

	always_ff @(posedge clk_sys or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_cas_to_core  <= 1'b0;
			o_audio_sample <= '0;
		end
		else
		begin
			o_cas_to_core  <= cas_src;
			o_audio_sample <= sample_nxt;
		end
	end

endmodule

/* design/cas_level_detect.sv */
// cassette level detector for the adc input.
// each toggle of the sync line brings one sample; a 512-sample running
// average follows the dc level and the cassette bit flips with hysteresis
// around it. polarity is inverted: low input gives a 1.

`include "coco_params.svh"

module cas_level_detect
(
	input  logic                        clk_sys,
	input  logic                        i_rst_n,
	input  coco_audio_pkg::adc_sample_t i_adc_data,
	input  logic                        i_adc_sync,
	output coco_audio_pkg::adc_sample_t o_adc_avg,
	output logic                        o_cas_bit
);
	import coco_audio_pkg::*;

	localparam int WIN = 1 << `COCO_AVG_LOG2;
	localparam logic [`COCO_ADC_W:0] THRESH = `COCO_CAS_THRESH;

	logic                      sync_q;
	logic                      sample_evt;
	adc_sample_t               hist [WIN];
	logic [`COCO_AVG_LOG2-1:0] wr_ptr;
	logic                      win_full;
	adc_sample_t               oldest;
	adc_sum_t                  sum_q;
	adc_sum_t                  sum_nxt;
	// one extra bit so adding the threshold cannot wrap
	logic [`COCO_ADC_W:0]      x_ext;
	logic [`COCO_ADC_W:0]      x_hi;
	logic [`COCO_ADC_W:0]      avg_ext;
	logic [`COCO_ADC_W:0]      avg_hi;

	// new sample whenever the sync line differs from last cycle
	assign sample_evt = sync_q ^ i_adc_sync;

	// entries not yet written count as zero until the window has wrapped
	assign oldest  = win_full ? hist[wr_ptr] : '0;
	assign sum_nxt = sum_q - adc_sum_t'(oldest) + adc_sum_t'(i_adc_data);

	assign x_ext   = {1'b0, i_adc_data};
	assign x_hi    = x_ext + THRESH;
	assign avg_ext = {1'b0, o_adc_avg};
	assign avg_hi  = avg_ext + THRESH;

	// circular history, oldest entry sits at the write pointer
	always_ff @(posedge clk_sys)
	begin
		if (sample_evt)
			hist[wr_ptr] <= i_adc_data;
	end

	always_ff @(posedge clk_sys or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			sync_q    <= 1'b0;
			wr_ptr    <= '0;
			win_full  <= 1'b0;
			sum_q     <= '0;
			o_adc_avg <= '0;
			o_cas_bit <= 1'b0;
		end
		else
		begin
			sync_q <= i_adc_sync;
			if (sample_evt)
			begin
				wr_ptr <= wr_ptr + 1'b1;
				if (&wr_ptr)
					win_full <= 1'b1;
				sum_q     <= sum_nxt;
				o_adc_avg <= sum_nxt[`COCO_AVG_LOG2 +: `COCO_ADC_W];
				// compare against the average from before this sample
				if (x_hi < avg_ext)
					o_cas_bit <= 1'b1;
				else if (x_ext > avg_hi)
					o_cas_bit <= 1'b0;
			end
		end
	end

endmodule

/* design/coco_audio_pkg.sv */
// sample-side types: raw adc samples, the running window total, the core's
// sound level and the final 16-bit audio sample.
// import this wherever the cassette or audio paths are handled.

`include "coco_params.svh"

package coco_audio_pkg;

	// one adc conversion
	typedef logic [`COCO_ADC_W-1:0] adc_sample_t;

	// sum over the whole window, wide enough for 512 full-scale samples
	typedef logic [`COCO_ADC_W+`COCO_AVG_LOG2-1:0] adc_sum_t;

	// dac level coming out of the core
	typedef logic [11:0] snd_level_t;

	// mono sample sent to both audio channels
	typedef logic [15:0] audio_sample_t;

endpackage

/* design/coco_cfg_if.sv */
// decoded control fields, driven from the control register and read by the
// reset sequencer and the audio mixer.
// the fields are held register bits, so there is no handshake.

interface coco_cfg_if;
	import coco_cfg_pkg::*;

	// core reset requested by software, held while set
	logic         soft_reset;
	// machine selection
	machine_sel_t machine_sel;
	// disk rom in place of the cartridge
	logic         disk_cart;
	// cassette comes from the adc instead of the tape player
	logic         tape_src_adc;
	// mix cassette into the audio output
	logic         monitor_tape;
	// toggling this asks for a hard reset
	logic         hard_req;

	// register side owns all fields
	modport regs
	(
		output soft_reset,
		output machine_sel,
		output disk_cart,
		output tape_src_adc,
		output monitor_tape,
		output hard_req
	);

	modport rst_seq
	(
		input machine_sel,
		input disk_cart,
		input hard_req,
		input soft_reset
	);

	modport mix
	(
		input tape_src_adc,
		input monitor_tape
	);

endinterface

/* design/coco_cfg_pkg.sv */
// control-side types for the glue block: axi4-lite address and data words,
// machine selection and the hard-reset FSM states.
// control word bit positions live here too, so the register block and the
// testbench agree on the layout.

`include "coco_params.svh"

package coco_cfg_pkg;

	// register port words
	typedef logic [`COCO_AXIL_AW-1:0] axil_addr_t;
	typedef logic [`COCO_AXIL_DW-1:0] axil_data_t;

	// 0 coco2, 1 dragon32, 2 dragon64, 3 counts as a plain dragon
	typedef logic [1:0] machine_sel_t;

	localparam machine_sel_t MACH_COCO2    = 2'd0;
	localparam machine_sel_t MACH_DRAGON64 = 2'd2;

	// hard-reset pulse sequencing
	typedef enum logic [1:0]
	{
		IDLE,
		ARM,
		PULSE
	} rst_state_t;

	// control word layout
	localparam int CTRL_SOFT_RST  = 0;
	localparam int CTRL_MACH_LO   = 1;
	localparam int CTRL_MACH_HI   = 2;
	localparam int CTRL_DISK_CART = 3;
	localparam int CTRL_TAPE_ADC  = 4;
	localparam int CTRL_MON_TAPE  = 5;
	localparam int CTRL_HARD_REQ  = 6;
	// number of implemented control bits
	localparam int CTRL_W         = 7;

endpackage

/* design/coco_ctl_regs.sv */
// axi4-lite slave holding the control word and a read-only status word.
// offset 0 is control, bits 6:0 writable; offset 4 is status
// (average, cassette bit, core reset). other offsets answer slverr.
// one write and one read may be outstanding at a time.

`include "coco_params.svh"

module coco_ctl_regs
(
	input  logic                        clk_sys,
	input  logic                        i_rst_n,
	// write address and data
	input  coco_cfg_pkg::axil_addr_t    i_axil_awaddr,
	input  logic                        i_axil_awvalid,
	output logic                        o_axil_awready,
	input  coco_cfg_pkg::axil_data_t    i_axil_wdata,
	input  logic [`COCO_AXIL_DW/8-1:0]  i_axil_wstrb,
	input  logic                        i_axil_wvalid,
	output logic                        o_axil_wready,
	// write response
	output logic [1:0]                  o_axil_bresp,
	output logic                        o_axil_bvalid,
	input  logic                        i_axil_bready,
	// read address and data
	input  coco_cfg_pkg::axil_addr_t    i_axil_araddr,
	input  logic                        i_axil_arvalid,
	output logic                        o_axil_arready,
	output coco_cfg_pkg::axil_data_t    o_axil_rdata,
	output logic [1:0]                  o_axil_rresp,
	output logic                        o_axil_rvalid,
	input  logic                        i_axil_rready,
	// status sources
	input  coco_audio_pkg::adc_sample_t i_adc_avg,
	input  logic                        i_cas_bit,
	input  logic                        i_core_reset,
	coco_cfg_if.regs                    cfg
);
	import coco_cfg_pkg::*;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic [CTRL_W-1:0] ctrl_q;
	logic              wr_ready_q;
	logic              rd_ready_q;
	logic              wr_hs;
	logic              rd_hs;
	logic              wr_ctrl;
	logic              rd_ctrl;
	logic              rd_stat;
	axil_data_t        stat_word;

	// aw and w are accepted together in the same cycle
	assign o_axil_awready = wr_ready_q;
	assign o_axil_wready  = wr_ready_q;
	assign o_axil_arready = rd_ready_q;

	assign wr_hs   = wr_ready_q & i_axil_awvalid & i_axil_wvalid;
	assign rd_hs   = rd_ready_q & i_axil_arvalid;
	assign wr_ctrl = (i_axil_awaddr == axil_addr_t'(`COCO_REG_CTRL));
	assign rd_ctrl = (i_axil_araddr == axil_addr_t'(`COCO_REG_CTRL));
	assign rd_stat = (i_axil_araddr == axil_addr_t'(`COCO_REG_STAT));

	// avg in 11:0, cassette bit 12, core reset 13
	assign stat_word = axil_data_t'({i_core_reset, i_cas_bit, i_adc_avg});

	//////////////////////////////////////////////////////////////////////////////
	// handshake and control state
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			wr_ready_q    <= 1'b0;
			rd_ready_q    <= 1'b0;
			o_axil_bvalid <= 1'b0;
			o_axil_rvalid <= 1'b0;
			ctrl_q        <= '0;
		end
		else
		begin
			// single-cycle ready pulse, only while no response is pending
			wr_ready_q <= i_axil_awvalid & i_axil_wvalid & ~o_axil_bvalid & ~wr_ready_q;
			rd_ready_q <= i_axil_arvalid & ~o_axil_rvalid & ~rd_ready_q;

			// response valid holds until the master takes it
			if (wr_hs)
				o_axil_bvalid <= 1'b1;
			else if (i_axil_bready)
				o_axil_bvalid <= 1'b0;

			if (rd_hs)
				o_axil_rvalid <= 1'b1;
			else if (i_axil_rready)
				o_axil_rvalid <= 1'b0;

			// only the low byte lane carries control bits
			if (wr_hs && wr_ctrl && i_axil_wstrb[0])
				ctrl_q <= i_axil_wdata[CTRL_W-1:0];
		end
	end

	// response payload, captured at the handshake
	always_ff @(posedge clk_sys)
	begin
		if (wr_hs)
			o_axil_bresp <= wr_ctrl ? RESP_OKAY : RESP_SLVERR;

		if (rd_hs)
		begin
			if (rd_ctrl)
			begin
				o_axil_rdata <= axil_data_t'(ctrl_q);
				o_axil_rresp <= RESP_OKAY;
			end
			else if (rd_stat)
			begin
				o_axil_rdata <= stat_word;
				o_axil_rresp <= RESP_OKAY;
			end
			else
			begin
				o_axil_rdata <= '0;
				o_axil_rresp <= RESP_SLVERR;
			end
		end
	end

	// decoded fields out to the sequencer and mixer
	assign cfg.soft_reset   = ctrl_q[CTRL_SOFT_RST];
	assign cfg.machine_sel  = ctrl_q[CTRL_MACH_HI:CTRL_MACH_LO];
	assign cfg.disk_cart    = ctrl_q[CTRL_DISK_CART];
	assign cfg.tape_src_adc = ctrl_q[CTRL_TAPE_ADC];
	assign cfg.monitor_tape = ctrl_q[CTRL_MON_TAPE];
	assign cfg.hard_req     = ctrl_q[CTRL_HARD_REQ];

endmodule

/* design/coco_glue_top.sv */
// top level of the cassette and system glue block.
// register port, adc detector, reset sequencer and audio mixer, all on
// clk_sys. the adc arrives as a sample word plus a toggling sync line.

`include "coco_params.svh"

module coco_glue_top
(
	input  logic                          clk_sys,
	input  logic                          i_rst_n,
	input  coco_cfg_pkg::axil_addr_t      i_axil_awaddr,
	input  logic                          i_axil_awvalid,
	output logic                          o_axil_awready,
	input  coco_cfg_pkg::axil_data_t      i_axil_wdata,
	input  logic [`COCO_AXIL_DW/8-1:0]    i_axil_wstrb,
	input  logic                          i_axil_wvalid,
	output logic                          o_axil_wready,
	output logic [1:0]                    o_axil_bresp,
	output logic                          o_axil_bvalid,
	input  logic                          i_axil_bready,
	input  coco_cfg_pkg::axil_addr_t      i_axil_araddr,
	input  logic                          i_axil_arvalid,
	output logic                          o_axil_arready,
	output coco_cfg_pkg::axil_data_t      o_axil_rdata,
	output logic [1:0]                    o_axil_rresp,
	output logic                          o_axil_rvalid,
	input  logic                          i_axil_rready,
	input  coco_audio_pkg::adc_sample_t   i_adc_data,
	input  logic                          i_adc_sync,
	input  logic                          i_tape_bit,
	input  logic                          i_snd_bit,
	input  coco_audio_pkg::snd_level_t    i_snd_level,
	output coco_audio_pkg::audio_sample_t o_audio_sample,
	output logic                          o_cas_to_core,
	output logic                          o_core_reset,
	output logic                          o_hard_reset,
	output logic                          o_dragon,
	output logic                          o_dragon64
);
	import coco_audio_pkg::*;

	// detector results shared by status and mixer
	adc_sample_t adc_avg;
	logic        adc_cas_bit;

	coco_cfg_if u_cfg_if ();

	//////////////////////////////////////////////////////////////////////////////
	// register port
	//////////////////////////////////////////////////////////////////////////////

	coco_ctl_regs u_regs
	(
		.clk_sys        (clk_sys),
		.i_rst_n        (i_rst_n),
		.i_axil_awaddr  (i_axil_awaddr),
		.i_axil_awvalid (i_axil_awvalid),
		.o_axil_awready (o_axil_awready),
		.i_axil_wdata   (i_axil_wdata),
		.i_axil_wstrb   (i_axil_wstrb),
		.i_axil_wvalid  (i_axil_wvalid),
		.o_axil_wready  (o_axil_wready),
		.o_axil_bresp   (o_axil_bresp),
		.o_axil_bvalid  (o_axil_bvalid),
		.i_axil_bready  (i_axil_bready),
		.i_axil_araddr  (i_axil_araddr),
		.i_axil_arvalid (i_axil_arvalid),
		.o_axil_arready (o_axil_arready),
		.o_axil_rdata   (o_axil_rdata),
		.o_axil_rresp   (o_axil_rresp),
		.o_axil_rvalid  (o_axil_rvalid),
		.i_axil_rready  (i_axil_rready),
		.i_adc_avg      (adc_avg),
		.i_cas_bit      (adc_cas_bit),
		.i_core_reset   (o_core_reset),
		.cfg            (u_cfg_if.regs)
	);

	//////////////////////////////////////////////////////////////////////////////
	// cassette detection and reset sequencing
	//////////////////////////////////////////////////////////////////////////////

	cas_level_detect u_detect
	(
		.clk_sys    (clk_sys),
		.i_rst_n    (i_rst_n),
		.i_adc_data (i_adc_data),
		.i_adc_sync (i_adc_sync),
		.o_adc_avg  (adc_avg),
		.o_cas_bit  (adc_cas_bit)
	);

	machine_reset_seq u_rst_seq
	(
		.clk_sys      (clk_sys),
		.i_rst_n      (i_rst_n),
		.cfg          (u_cfg_if.rst_seq),
		.o_core_reset (o_core_reset),
		.o_hard_reset (o_hard_reset),
		.o_dragon     (o_dragon),
		.o_dragon64   (o_dragon64)
	);

	// audio and cassette out to the core
	cas_audio_mix u_mix
	(
		.clk_sys        (clk_sys),
		.i_rst_n        (i_rst_n),
		.cfg            (u_cfg_if.mix),
		.i_adc_cas_bit  (adc_cas_bit),
		.i_tape_bit     (i_tape_bit),
		.i_snd_bit      (i_snd_bit),
		.i_snd_level    (i_snd_level),
		.o_cas_to_core  (o_cas_to_core),
		.o_audio_sample (o_audio_sample)
	);

endmodule

/* design/coco_params.svh */
// shared sizes, window length, thresholds and register map for the
// cassette and system glue block.
// include this file in any package or module that needs one of these values.

`ifndef COCO_PARAMS_SVH
`define COCO_PARAMS_SVH

// adc sample width in bits
`define COCO_ADC_W       12
// log2 of the averaging window, 9 gives 512 samples
`define COCO_AVG_LOG2    9
// hysteresis distance from the running average, in adc counts
`define COCO_CAS_THRESH  100
// number of cycles the core reset is stretched after a config change
`define COCO_RST_HOLD    15

// axi4-lite register port
`define COCO_AXIL_AW     4
`define COCO_AXIL_DW     32

// register byte offsets
`define COCO_REG_CTRL    0
`define COCO_REG_STAT    4

`endif

/* design/machine_reset_seq.sv */
// reset sequencer for machine and cartridge changes.
// any change of machine, disk/cart choice or the hard-reset request stretches
// the core reset for COCO_RST_HOLD cycles and fires one hard-reset pulse
// inside that window. also decodes the dragon flags.

`include "coco_params.svh"

module machine_reset_seq
(
	input  logic        clk_sys,
	input  logic        i_rst_n,
	coco_cfg_if.rst_seq cfg,
	output logic        o_core_reset,
	output logic        o_hard_reset,
	output logic        o_dragon,
	output logic        o_dragon64
);
	import coco_cfg_pkg::*;

	localparam int CNT_W  = $clog2(`COCO_RST_HOLD + 1);
	localparam int SNAP_W = $bits(machine_sel_t) + 2;
	localparam logic [CNT_W-1:0] HOLD = CNT_W'(`COCO_RST_HOLD);

	logic [SNAP_W-1:0] snap_now;
	logic [SNAP_W-1:0] snap_q;
	logic              cfg_chg;
	logic [CNT_W-1:0]  hold_cnt;
	rst_state_t        state_q;
	rst_state_t        state_nxt;

	// soft reset is not part of the snapshot, it acts directly
	assign snap_now = {cfg.machine_sel, cfg.disk_cart, cfg.hard_req};
	assign cfg_chg  = (snap_now != snap_q);

	// pulse FSM, a fresh change always rearms it
	always_comb
	begin
		case (state_q)
			IDLE:    state_nxt = IDLE;
			ARM:     state_nxt = PULSE;
			PULSE:   state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
		if (cfg_chg)
			state_nxt = ARM;
	end

	always_ff @(posedge clk_sys or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			snap_q     <= '0;
			hold_cnt   <= '0;
			state_q    <= IDLE;
			o_dragon   <= 1'b0;
			o_dragon64 <= 1'b0;
		end
		else
		begin
			snap_q  <= snap_now;
			state_q <= state_nxt;
			// reload on every change so the window restarts
			if (cfg_chg)
				hold_cnt <= HOLD;
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			o_dragon   <= (cfg.machine_sel != MACH_COCO2);
			o_dragon64 <= (cfg.machine_sel == MACH_DRAGON64);
		end
	end

	assign o_hard_reset = (state_q == PULSE);
	assign o_core_reset = (hold_cnt != '0) | cfg.soft_reset;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the glue testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f all.f --top-module tb_coco_glue -o tb_coco_glue

out="$(./obj_dir/tb_coco_glue)"
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
else
	echo "testbench did not report a pass"
	exit 1
fi

/* verification/tb_coco_glue.sv */
// self-checking testbench for the cassette and system glue top level.
// drives the axi4-lite port, adc samples and audio inputs, models the
// detector and mixer in reference functions and compares in one process.
// run through all.f with the testbench as top module.

`include "coco_params.svh"

module tb_coco_glue;
	import coco_cfg_pkg::*;
	import coco_audio_pkg::*;

	localparam int N_SAMPLES = 1100;
	// 6 cycles per sample plus register, reset and mixer tests, with margin
	localparam int LIMIT     = N_SAMPLES * 10 + 1000;
	localparam int BAND_LEN  = 48;
	localparam logic [1:0] OKAY   = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	logic clk_sys;
	logic i_rst_n;
	axil_addr_t i_axil_awaddr, i_axil_araddr;
	axil_data_t i_axil_wdata, o_axil_rdata;
	logic [`COCO_AXIL_DW/8-1:0] i_axil_wstrb;
	logic i_axil_awvalid, o_axil_awready, i_axil_wvalid, o_axil_wready;
	logic [1:0] o_axil_bresp, o_axil_rresp;
	logic o_axil_bvalid, i_axil_bready, i_axil_arvalid, o_axil_arready;
	logic o_axil_rvalid, i_axil_rready;
	adc_sample_t i_adc_data;
	logic i_adc_sync, i_tape_bit, i_snd_bit;
	snd_level_t i_snd_level;
	audio_sample_t o_audio_sample;
	logic o_cas_to_core, o_core_reset, o_hard_reset, o_dragon, o_dragon64;

	// detector reference state
	int          ref_hist [1 << `COCO_AVG_LOG2];
	int          ref_ptr;
	int          ref_sum;
	logic [11:0] ref_avg;
	logic        ref_cas;

	// pending comparisons drained by the checker
	logic [31:0] exp_q [$];
	logic [31:0] got_q [$];
	string       tag_q [$];
	logic [31:0] cmp_exp, cmp_got;
	string       cmp_tag;

	int     check_errors, proto_errors, checks_run, cycle_cnt;
	integer seed;

	coco_glue_top DUT (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// run limit
	always @(posedge clk_sys)
	begin
		cycle_cnt++;
		if (cycle_cnt >= LIMIT)
		begin
			$display("timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// comparison
	//////////////////////////////////////////////////////////////////////////

	always @(posedge clk_sys)
	begin
		while (got_q.size() > 0)
		begin
			cmp_exp = exp_q.pop_front();
			cmp_got = got_q.pop_front();
			cmp_tag = tag_q.pop_front();
			checks_run++;
			assert (cmp_got == cmp_exp)
			else
			begin
				check_errors++;
				$display("CHECK FAILED at %0t: %s, expected %h got %h",
					$time, cmp_tag, cmp_exp, cmp_got);
			end
		end
	end

	task automatic expect_val(input logic [31:0] exp, input logic [31:0] got, input string what);
		exp_q.push_back(exp);
		got_q.push_back(got);
		tag_q.push_back(what);
	endtask

	// one clock then settle just past the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////////
	// reference models
	//////////////////////////////////////////////////////////////////////////

	// running sum over 512 samples with hysteresis against the old average
	function void detect_ref(input int x);
		if (x + `COCO_CAS_THRESH < int'(ref_avg))
			ref_cas = 1'b1;
		else if (x > int'(ref_avg) + `COCO_CAS_THRESH)
			ref_cas = 1'b0;
		ref_sum = ref_sum - ref_hist[ref_ptr] + x;
		ref_hist[ref_ptr] = x;
		ref_ptr = (ref_ptr + 1) % (1 << `COCO_AVG_LOG2);
		ref_avg = 12'(ref_sum >> `COCO_AVG_LOG2);
	endfunction

	function logic [15:0] mix_ref(input logic snd, input logic [11:0] lvl, input logic src,
		input logic mon_en);
		logic mon;
		mon = mon_en & src;
		return {snd, lvl[11:6], lvl[5] ^ mon, lvl[4:0], 3'b000};
	endfunction

	// {dragon, dragon64}
	function logic [1:0] dragon_ref(input logic [1:0] sel);
		return {sel != 2'd0, sel == 2'd2};
	endfunction

	//////////////////////////////////////////////////////////////////////////
	// bus tasks
	//////////////////////////////////////////////////////////////////////////

	task automatic axil_write(input int addr, input axil_data_t data, input logic [3:0] strb,
		output logic [1:0] resp);
		int n;
		i_axil_awaddr  = axil_addr_t'(addr);
		i_axil_wdata   = data;
		i_axil_wstrb   = strb;
		i_axil_awvalid = 1'b1;
		i_axil_wvalid  = 1'b1;
		n = 0;
		resp = 2'b11;
		while (!o_axil_awready && n < 20)
		begin
			next_cycle();
			n++;
		end
		if (!o_axil_awready)
		begin
			proto_errors++;
			$display("write to address %0d was never accepted", addr);
		end
		else
		begin
			expect_val(1, o_axil_wready, "wready together with awready");
			// handshake happens on this edge
			next_cycle();
		end
		i_axil_awvalid = 1'b0;
		i_axil_wvalid  = 1'b0;
		n = 0;
		while (!o_axil_bvalid && n < 20)
		begin
			next_cycle();
			n++;
		end
		if (!o_axil_bvalid)
		begin
			proto_errors++;
			$display("write response to address %0d never arrived", addr);
		end
		else
			resp = o_axil_bresp;
	endtask

	task automatic axil_read(input int addr, output axil_data_t data, output logic [1:0] resp);
		int n;
		i_axil_araddr  = axil_addr_t'(addr);
		i_axil_arvalid = 1'b1;
		n = 0;
		data = '1;
		resp = 2'b11;
		while (!o_axil_arready && n < 20)
		begin
			next_cycle();
			n++;
		end
		if (o_axil_arready)
			next_cycle();
		i_axil_arvalid = 1'b0;
		n = 0;
		while (!o_axil_rvalid && n < 20)
		begin
			next_cycle();
			n++;
		end
		if (!o_axil_rvalid)
		begin
			proto_errors++;
			$display("read of address %0d got no response", addr);
		end
		else
		begin
			data = o_axil_rdata;
			resp = o_axil_rresp;
		end
	endtask

	// counts reset activity over a window of cycles
	task automatic watch_reset(input int n, output int core_n, output int core_runs,
		output int hard_n, output int hard_out);
		logic prev;
		prev = o_core_reset;
		core_n = 0;
		core_runs = 0;
		hard_n = 0;
		hard_out = 0;
		for (int i = 0; i < n; i++)
		begin
			next_cycle();
			if (o_core_reset)
				core_n++;
			if (o_core_reset && !prev)
				core_runs++;
			prev = o_core_reset;
			if (o_hard_reset)
			begin
				hard_n++;
				if (!o_core_reset)
					hard_out++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////////

	initial
	begin
		axil_data_t  rdata;
		logic [1:0]  resp;
		int          core_n, core_runs, hard_n, hard_out, x;
		logic [1:0]  sel;
		logic [11:0] lvl;

		seed = 32'h7c5b8d77;
		i_rst_n = 1'b0;
		i_axil_awaddr = '0;
		i_axil_awvalid = 1'b0;
		i_axil_wdata = '0;
		i_axil_wstrb = '0;
		i_axil_wvalid = 1'b0;
		i_axil_bready = 1'b1;
		i_axil_araddr = '0;
		i_axil_arvalid = 1'b0;
		i_axil_rready = 1'b1;
		i_adc_data = '0;
		i_adc_sync = 1'b0;
		i_tape_bit = 1'b0;
		i_snd_bit = 1'b0;
		i_snd_level = '0;
		ref_ptr = 0;
		ref_sum = 0;
		ref_avg = '0;
		ref_cas = 1'b0;
		foreach (ref_hist[i])
			ref_hist[i] = 0;
		repeat (5) @(posedge clk_sys);
		#1 i_rst_n = 1'b1;
		next_cycle();

		// register access and error responses
		axil_write(`COCO_REG_CTRL, 32'hffff_ff55, 4'hf, resp);
		expect_val(OKAY, resp, "ctrl write response");
		axil_read(`COCO_REG_CTRL, rdata, resp);
		expect_val(32'h55, rdata, "ctrl readback");
		axil_write(`COCO_REG_STAT, 32'h0000_002a, 4'hf, resp);
		expect_val(SLVERR, resp, "stat write response");
		axil_write(`COCO_REG_CTRL, 32'h0000_002a, 4'he, resp);
		expect_val(OKAY, resp, "ctrl write without lane 0");
		axil_read(`COCO_REG_CTRL, rdata, resp);
		expect_val(32'h55, rdata, "ctrl after ignored writes");
		axil_read(8, rdata, resp);
		expect_val(SLVERR, resp, "unused address read response");
		expect_val(0, rdata, "unused address read data");

		// bready held low blocks the next write
		i_axil_bready = 1'b0;
		axil_write(`COCO_REG_CTRL, 32'h11, 4'h1, resp);
		i_axil_awaddr = axil_addr_t'(`COCO_REG_CTRL);
		i_axil_wdata = 32'h00;
		i_axil_awvalid = 1'b1;
		i_axil_wvalid = 1'b1;
		repeat (6)
		begin
			next_cycle();
			expect_val(1, o_axil_bvalid, "bvalid held while bready low");
			expect_val(0, o_axil_awready, "awready while response pending");
			expect_val(0, o_axil_wready, "wready while response pending");
		end
		i_axil_bready = 1'b1;
		axil_write(`COCO_REG_CTRL, 32'h00, 4'h1, resp);
		axil_read(`COCO_REG_CTRL, rdata, resp);
		expect_val(0, rdata, "ctrl after stalled write");
		repeat (20) next_cycle();

		// machine change gives a 15-cycle reset and a single pulse
		for (int s = 1; s <= 4; s++)
		begin
			sel = 2'(s);
			axil_write(`COCO_REG_CTRL, axil_data_t'({sel, 1'b0}), 4'h1, resp);
			watch_reset(30, core_n, core_runs, hard_n, hard_out);
			expect_val(`COCO_RST_HOLD, core_n, "core reset length");
			expect_val(1, core_runs, "core reset runs");
			expect_val(1, hard_n, "hard reset pulses");
			expect_val(0, hard_out, "hard reset outside window");
			expect_val(dragon_ref(sel), {o_dragon, o_dragon64}, "machine decode");
			axil_write(`COCO_REG_CTRL, axil_data_t'({sel, 1'b0}), 4'h1, resp);
			watch_reset(30, core_n, core_runs, hard_n, hard_out);
			expect_val(0, core_n + hard_n, "reset on unchanged rewrite");
		end

		// soft reset follows the control bit
		axil_write(`COCO_REG_CTRL, 32'h01, 4'h1, resp);
		watch_reset(10, core_n, core_runs, hard_n, hard_out);
		expect_val(10, core_n, "core reset under soft reset");
		expect_val(0, hard_n, "hard reset under soft reset");
		axil_read(`COCO_REG_STAT, rdata, resp);
		expect_val(1, rdata[13], "stat core reset bit set");
		axil_write(`COCO_REG_CTRL, 32'h00, 4'h1, resp);
		next_cycle();
		expect_val(0, o_core_reset, "core reset after soft clear");
		axil_read(`COCO_REG_STAT, rdata, resp);
		expect_val(0, rdata[13], "stat core reset bit clear");

		// adc detector with alternating bands so the cassette bit toggles
		axil_write(`COCO_REG_CTRL, 32'h10, 4'h1, resp);
		for (int i = 0; i < N_SAMPLES; i++)
		begin
			if ((i / BAND_LEN) % 2 == 1)
				x = 2800 + int'($unsigned($random(seed)) % 1200);
			else
				x = 300 + int'($unsigned($random(seed)) % 900);
			i_adc_data = adc_sample_t'(x);
			i_adc_sync = ~i_adc_sync;
			detect_ref(x);
			next_cycle();
			axil_read(`COCO_REG_STAT, rdata, resp);
			expect_val({18'd0, 1'b0, ref_cas, ref_avg}, rdata, "stat after sample");
			expect_val(ref_cas, o_cas_to_core, "adc cassette to core");
			next_cycle();
			next_cycle();
			next_cycle();
		end

		// mixer under every source and monitor setting
		for (int m = 0; m < 4; m++)
		begin
			axil_write(`COCO_REG_CTRL, axil_data_t'({m[1], m[0], 4'b0000}), 4'h1, resp);
			repeat (40)
			begin
				lvl = 12'($random(seed));
				i_snd_level = lvl;
				i_snd_bit = 1'($random(seed));
				i_tape_bit = 1'($random(seed));
				next_cycle();
				next_cycle();
				expect_val(mix_ref(i_snd_bit, lvl, m[0] ? ref_cas : i_tape_bit, m[1]),
					o_audio_sample, "audio sample");
				expect_val(m[0] ? ref_cas : i_tape_bit, o_cas_to_core, "cassette source");
			end
		end

		next_cycle();
		next_cycle();
		$display("checks run %0d, check errors %0d, protocol errors %0d",
			checks_run, check_errors, proto_errors);
		if (check_errors == 0 && proto_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
